// ==== verilog/lcd_touch_pkg.sv ====
// touch-side types and button bounds; coordinates are raw 10-bit panel units with no calibration
package lcd_touch_pkg;

    // four bytes in arrival order from the touch controller
    typedef struct packed {
        logic [7:0] x_low;   // first byte, top of the word
        logic [7:0] x_high;
        logic [7:0] y_low;
        logic [7:0] y_high;  // last byte
    } touch_coord_t;

    // layout seen by the host at address 0
    typedef struct packed {
        logic       valid;   // touch or release in progress
        logic [10:0] rsvd;   // always zero
        logic [9:0] x;
        logic [9:0] y;
    } touch_reg_t;

    // start button rectangle, bounds inclusive
    localparam logic [15:0] BTN_X_MIN = 16'h0028;
    localparam logic [15:0] BTN_X_MAX = 16'h01B7;
    localparam logic [15:0] BTN_Y_MIN = 16'h0028;
    localparam logic [15:0] BTN_Y_MAX = 16'h02F7;

endpackage

// ==== verilog/lcd_draw_pkg.sv ====
// lcd bus word and command sequences; rom contents target an ili-style controller with 16-bit pixels
package lcd_draw_pkg;

    typedef struct packed {
        logic        dc;     // 0 command, 1 data
        logic [15:0] data;
    } lcd_word_t;

    localparam int INIT_LEN  = 8;
    localparam int CLEAR_LEN = 4;

    // step counter widths, sized by the longer sequence
    localparam int INIT_AW  = $clog2(INIT_LEN);
    localparam int CLEAR_AW = $clog2(CLEAR_LEN);

    // start-up sequence
    localparam lcd_word_t INIT_ROM [INIT_LEN] = '{
        '{1'b0, 16'h0011},   // sleep out
        '{1'b0, 16'h003A},   // pixel format
        '{1'b1, 16'h0055},   // 16 bpp
        '{1'b0, 16'h0036},   // memory access control
        '{1'b1, 16'h0048},
        '{1'b0, 16'h0029},   // display on
        '{1'b0, 16'h002C},   // memory write
        '{1'b1, 16'h0000}
    };

    // clear screen before the game starts
    localparam lcd_word_t CLEAR_ROM [CLEAR_LEN] = '{
        '{1'b0, 16'h002A},   // column address
        '{1'b1, 16'h0000},
        '{1'b0, 16'h002C},   // memory write
        '{1'b1, 16'h0000}    // black
    };

endpackage

// ==== verilog/lcd_touch_scanner.sv ====
// touch byte assembler; expects bytes already framed, four per coordinate, only while the pen is down
module lcd_touch_scanner (
    input  logic                        pclk,
    input  logic                        rst_n,
    input  logic                        enable,
    input  logic [7:0]                  tp_byte,
    input  logic                        tp_valid,
    input  logic                        tp_pen,
    output lcd_touch_pkg::touch_coord_t coordinate,
    output logic                        touch_flag,
    output logic                        release_flag
);

    logic [1:0]  byte_cnt;    // bytes of the current frame
    logic [23:0] byte_shift;  // first three bytes of the frame
    logic        pen_q;
    logic        coord_held;  // a full frame came in during this pen-down

    wire last_byte = tp_valid && tp_pen && (byte_cnt == 2'd3);
    wire pen_fall  = pen_q && !tp_pen;

    // control state frozen while disabled
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            byte_cnt     <= '0;
            pen_q        <= 1'b0;
            coord_held   <= 1'b0;
            touch_flag   <= 1'b0;
            release_flag <= 1'b0;
        end else if (enable) begin
            pen_q        <= tp_pen;
            release_flag <= pen_fall && coord_held;

            if (!tp_pen) begin
                byte_cnt   <= '0;   // pen up restarts framing
                touch_flag <= 1'b0;
            end else if (tp_valid) begin
                byte_cnt <= byte_cnt + 2'd1;
            end

            if (last_byte) begin
                coord_held <= 1'b1;
                touch_flag <= 1'b1;
            end else if (pen_fall) begin
                coord_held <= 1'b0;  // one release per pen-down
            end
        end else begin
            release_flag <= 1'b0;
        end
    end

    // byte path
    always_ff @(posedge pclk) begin
        if (enable && tp_pen && tp_valid) begin
            byte_shift <= {byte_shift[15:0], tp_byte};
            if (byte_cnt == 2'd3) begin
                coordinate <= {byte_shift, tp_byte};  // held until the next full frame
            end
        end
    end

endmodule

// ==== verilog/lcd_init.sv ====
// lcd sequencer; plays INIT_ROM once after reset, CLEAR_ROM per request, requests during a pass are lost
module lcd_init (
    input  logic                    pclk,
    input  logic                    rst_n,
    input  logic                    init_main,
    output logic                    init_finish,
    output logic                    init_wr,
    output lcd_draw_pkg::lcd_word_t init_word
);

    import lcd_draw_pkg::*;

    logic [INIT_AW-1:0] step;
    logic               busy;
    logic               clear_mode;  // 1 while replaying the clear sequence
    logic               last_step;

    always_comb begin
        if (clear_mode) begin
            last_step = (step == INIT_AW'(CLEAR_LEN - 1));
        end else begin
            last_step = (step == INIT_AW'(INIT_LEN - 1));
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            step        <= '0;
            busy        <= 1'b1;      // start-up pass begins right after reset
            clear_mode  <= 1'b0;
            init_wr     <= 1'b0;
            init_finish <= 1'b0;
        end else begin
            if (busy) begin
                init_wr <= 1'b1;
                step    <= step + INIT_AW'(1);
                if (last_step) begin
                    busy <= 1'b0;
                end
            end else if (init_main) begin
                // first clear word goes out right away
                init_wr    <= 1'b1;
                step       <= INIT_AW'(1);
                clear_mode <= 1'b1;
                busy       <= (CLEAR_LEN > 1);
            end else begin
                init_wr <= 1'b0;
            end

            if (init_wr && !busy) begin
                init_finish <= 1'b1;  // sticky, cycle after the last word
            end
        end
    end

    // word payload
    always_ff @(posedge pclk) begin
        if (busy) begin
            init_word <= clear_mode ? CLEAR_ROM[step[CLEAR_AW-1:0]] : INIT_ROM[step];
        end else if (init_main) begin
            init_word <= CLEAR_ROM[0];
        end
    end

endmodule

// ==== verilog/lcd_core.sv ====
// panel state machine; game state is terminal, only reset leaves it
module lcd_core (
    input  logic                        pclk,
    input  logic                        rst_n,
    input  logic                        init_finish,
    output logic                        init_main,
    output lcd_touch_pkg::touch_reg_t   touch_reg,
    output logic                        cpu_draw,
    input  logic                        touch_flag,
    input  logic                        release_flag,
    input  lcd_touch_pkg::touch_coord_t coordinate,
    output logic                        enable
);

    import lcd_touch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        INITIAL,
        MAIN,
        GAME
    } core_state_t;

    core_state_t core_state;

    logic [15:0] cx;
    logic [15:0] cy;
    logic        in_button;

    // bytes arrive low first
    assign cx = {coordinate.x_high, coordinate.x_low};
    assign cy = {coordinate.y_high, coordinate.y_low};

    assign in_button = (cx >= BTN_X_MIN) && (cx <= BTN_X_MAX) &&
                       (cy >= BTN_Y_MIN) && (cy <= BTN_Y_MAX);

    always_comb begin
        touch_reg       = '0;
        touch_reg.valid = touch_flag | release_flag;
        touch_reg.x     = cx[9:0];
        touch_reg.y     = cy[9:0];
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            core_state <= IDLE;
            enable     <= 1'b0;
            init_main  <= 1'b0;
            cpu_draw   <= 1'b0;
        end else begin
            case (core_state)
                IDLE: core_state <= INITIAL;
                INITIAL: begin
                    if (init_finish) begin
                        enable     <= 1'b1;  // touch scanner on
                        core_state <= MAIN;
                    end
                end
                MAIN: begin
                    if (release_flag && in_button) begin
                        core_state <= GAME;
                        cpu_draw   <= 1'b1;  // bus goes to the cpu
                        init_main  <= 1'b1;  // ask for clear screen
                    end
                end
                GAME: init_main <= 1'b0;
                default: core_state <= IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/lcd_mux.sv ====
// lcd bus selector, one cycle latency; init words win, losing cpu words are dropped
module lcd_mux (
    input  logic                    pclk,
    input  logic                    rst_n,
    input  logic                    cpu_draw,
    input  logic                    init_wr,
    input  lcd_draw_pkg::lcd_word_t init_word,
    input  logic                    cpu_wr,
    input  lcd_draw_pkg::lcd_word_t cpu_word,
    output logic                    lcd_wr,
    output lcd_draw_pkg::lcd_word_t lcd_word
);

    logic cpu_pass;

    // cpu only gets the bus in game state with no init word pending
    assign cpu_pass = cpu_wr && cpu_draw && !init_wr;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            lcd_wr <= 1'b0;
        end else begin
            lcd_wr <= init_wr | cpu_pass;
        end
    end

    // bus word holds when idle
    always_ff @(posedge pclk) begin
        if (init_wr) begin
            lcd_word <= init_word;
        end else if (cpu_pass) begin
            lcd_word <= cpu_word;
        end
    end

endmodule

// ==== verilog/lcd_ctrl.sv ====
// host status port; read data valid one cycle after host_rd, count wraps at 16 bits
module lcd_ctrl (
    input  logic                      pclk,
    input  logic                      rst_n,
    input  lcd_touch_pkg::touch_reg_t touch_reg,
    input  logic                      cpu_draw,
    input  logic                      init_finish,
    input  logic                      host_rd,
    input  logic [1:0]                host_addr,
    output logic [31:0]               host_rdata
);

    import lcd_touch_pkg::*;

    touch_reg_t  touch_latch;
    logic        valid_q;
    logic [15:0] touch_cnt;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            touch_latch <= '0;
            touch_cnt   <= '0;
            host_rdata  <= '0;
        end else begin
            valid_q <= touch_reg.valid;
            if (touch_reg.valid) begin
                touch_latch <= touch_reg;  // follow the latest frame of this touch
            end
            if (touch_reg.valid && !valid_q) begin
                touch_cnt <= touch_cnt + 16'd1;  // one per pen-down
            end

            if (host_rd) begin
                case (host_addr)
                    2'd0:    host_rdata <= touch_latch;
                    2'd1:    host_rdata <= {16'd0, touch_cnt};
                    2'd2:    host_rdata <= {30'd0, cpu_draw, init_finish};
                    default: host_rdata <= '0;
                endcase
            end
        end
    end

endmodule

// ==== verilog/lcd_top.sv ====
// lcd touch front end top; cpu words reach the panel only in game state and never beside an init word
module lcd_top (
    input  logic                    pclk,
    input  logic                    rst_n,
    // touch controller
    input  logic [7:0]              tp_byte,
    input  logic                    tp_valid,
    input  logic                    tp_pen,
    // cpu drawing path
    input  logic                    cpu_wr,
    input  lcd_draw_pkg::lcd_word_t cpu_word,
    // lcd bus
    output logic                    lcd_wr,
    output lcd_draw_pkg::lcd_word_t lcd_word,
    // host status
    input  logic                    host_rd,
    input  logic [1:0]              host_addr,
    output logic [31:0]             host_rdata
);

    import lcd_touch_pkg::*;
    import lcd_draw_pkg::*;

    touch_coord_t coordinate;
    touch_reg_t   touch_reg;
    lcd_word_t    init_word;
    logic         touch_flag;
    logic         release_flag;
    logic         enable;
    logic         init_finish;
    logic         init_main;
    logic         init_wr;
    logic         cpu_draw;

    lcd_touch_scanner u_scanner (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .enable       (enable),
        .tp_byte      (tp_byte),
        .tp_valid     (tp_valid),
        .tp_pen       (tp_pen),
        .coordinate   (coordinate),
        .touch_flag   (touch_flag),
        .release_flag (release_flag)
    );

    lcd_init u_init (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .init_main   (init_main),
        .init_finish (init_finish),
        .init_wr     (init_wr),
        .init_word   (init_word)
    );

    lcd_core u_core (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .init_finish  (init_finish),
        .init_main    (init_main),
        .touch_reg    (touch_reg),
        .cpu_draw     (cpu_draw),
        .touch_flag   (touch_flag),
        .release_flag (release_flag),
        .coordinate   (coordinate),
        .enable       (enable)
    );

    lcd_mux u_mux (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .cpu_draw  (cpu_draw),
        .init_wr   (init_wr),
        .init_word (init_word),
        .cpu_wr    (cpu_wr),
        .cpu_word  (cpu_word),
        .lcd_wr    (lcd_wr),
        .lcd_word  (lcd_word)
    );

    lcd_ctrl u_ctrl (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .touch_reg   (touch_reg),
        .cpu_draw    (cpu_draw),
        .init_finish (init_finish),
        .host_rd     (host_rd),
        .host_addr   (host_addr),
        .host_rdata  (host_rdata)
    );

endmodule

// ==== sim/tb_lcd_table.svh ====
// tap table and compare tasks included by tb_lcd_top after its package imports
`ifndef TB_LCD_TABLE_SVH
`define TB_LCD_TABLE_SVH

typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    logic        lift;  // pen goes up after the frame
    logic        game;  // game entry expected
} tap_row_t;

localparam int NUM_TAPS = 7;

tap_row_t tap_table [NUM_TAPS];

// start button hit with inclusive bounds
function automatic logic in_start_button(input logic [15:0] x, input logic [15:0] y);
    return (x >= BTN_X_MIN) && (x <= BTN_X_MAX) && (y >= BTN_Y_MIN) && (y <= BTN_Y_MAX);
endfunction

task automatic add_tap(input int idx, input logic [15:0] x, input logic [15:0] y,
                       input logic lift);
    tap_table[idx].x    = x;
    tap_table[idx].y    = y;
    tap_table[idx].lift = lift;
    tap_table[idx].game = lift && in_start_button(x, y);  // only a release inside counts
endtask

task automatic fill_tap_table();
    add_tap(0, 16'h0027, 16'h0100, 1'b1);  // one left of the button
    add_tap(1, 16'h01B8, 16'h0100, 1'b1);  // one right
    add_tap(2, 16'h0100, 16'h0027, 1'b1);  // one below
    add_tap(3, 16'h0100, 16'h02F8, 1'b1);  // one above
    // inside the button but the pen stays down into the next row
    add_tap(4, 16'h0100, 16'h0200, 1'b0);
    add_tap(5, 16'h0300, 16'h0010, 1'b1);
    add_tap(6, 16'h0028, 16'h02F7, 1'b1);  // corner of the button
endtask

task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
endtask

task automatic check_word(input string name, input lcd_word_t got, input lcd_word_t want);
    if (got !== want) begin
        fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
endtask

task automatic check_touch(input string name, input touch_reg_t got, input touch_reg_t want);
    if (got !== want) begin
        fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
endtask

task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
        fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
endtask

`endif

// ==== sim/tb_lcd_top.sv ====
// testbench for lcd_top with pre-framed touch bytes and a stop at the first mismatch
module tb_lcd_top;
    timeunit 1ns;
    timeprecision 1ps;

    import lcd_touch_pkg::*;
    import lcd_draw_pkg::*;

    logic        pclk;
    logic        rst_n;
    logic [7:0]  tp_byte;
    logic        tp_valid;
    logic        tp_pen;
    logic        cpu_wr;
    lcd_word_t   cpu_word;
    logic        lcd_wr;
    lcd_word_t   lcd_word;
    logic        host_rd;
    logic [1:0]  host_addr;
    logic [31:0] host_rdata;
    integer      seed = 32'h4a32;
    logic        bus_quiet = 1'b0;  // set while cpu words must stay off the bus

    `include "tb_lcd_table.svh"

    lcd_top UUT (.*);

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    // one read with data back one cycle after host_rd
    task automatic read_host(input logic [1:0] addr, output logic [31:0] data);
        @(posedge pclk);
        host_rd   <= 1'b1;
        host_addr <= addr;
        @(posedge pclk);
        host_rd <= 1'b0;
        @(negedge pclk);
        data = host_rdata;
    endtask

    // waits for the first word then expects the whole rom back to back
    task automatic check_bus_words(input logic clear_seq);
        int        len;
        int        n;
        lcd_word_t want;
        len = clear_seq ? CLEAR_LEN : INIT_LEN;
        n   = 0;
        @(negedge pclk);
        while (lcd_wr !== 1'b1) begin
            if (n == 40) begin
                fail_stop("timed out waiting for a command sequence on the LCD bus");
            end
            @(negedge pclk);
            n++;
        end
        for (int i = 0; i < len; i++) begin
            want = clear_seq ? CLEAR_ROM[i] : INIT_ROM[i];
            check_flag("lcd_wr", lcd_wr, 1'b1);
            check_word("lcd_word", lcd_word, want);
            @(negedge pclk);
        end
        check_flag("lcd_wr", lcd_wr, 1'b0);
    endtask

    // pen down, four bytes low first, then pen up if the row lifts
    task automatic apply_tap(input tap_row_t row);
        logic [7:0] frame [4];
        frame[0] = row.x[7:0];
        frame[1] = row.x[15:8];
        frame[2] = row.y[7:0];
        frame[3] = row.y[15:8];
        @(posedge pclk);
        tp_pen <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(posedge pclk);
            tp_valid <= 1'b1;
            tp_byte  <= frame[i];
        end
        @(posedge pclk);
        tp_valid <= 1'b0;
        if (row.lift) begin
            @(posedge pclk);
            tp_pen <= 1'b0;
        end
    endtask

    always @(negedge pclk) begin
        if (bus_quiet) begin
            check_flag("lcd_wr", lcd_wr, 1'b0);
        end
    end

    initial begin
        tap_row_t    row;
        touch_reg_t  touch_exp;
        lcd_word_t   prev_word;
        logic [31:0] rdata;
        logic [31:0] rnd;
        int          lifts;

        rst_n     = 1'b0;
        tp_byte   = '0;
        tp_valid  = 1'b0;
        tp_pen    = 1'b0;
        cpu_wr    = 1'b0;
        cpu_word  = '0;
        host_rd   = 1'b0;
        host_addr = '0;
        lifts     = 0;
        prev_word = '0;
        fill_tap_table();

        repeat (4) @(posedge pclk);
        rst_n <= 1'b1;

        // start-up words and an early status read run side by side
        fork
            begin
                @(negedge pclk);
                check_flag("lcd_wr", lcd_wr, 1'b0);
                check_bus_words(1'b0);
            end
            begin
                read_host(2'd2, rdata);
                check_data("status", rdata, 32'h0);
            end
        join
        read_host(2'd2, rdata);
        check_data("status", rdata, 32'h1);  // init_finish only

        bus_quiet = 1'b1;
        for (int t = 0; t < NUM_TAPS; t++) begin
            row = tap_table[t];
            rnd = $random(seed);
            @(posedge pclk);
            cpu_wr   <= !row.game;  // dropped by the mux before game state
            cpu_word <= rnd[16:0];
            if (row.game) begin
                bus_quiet = 1'b0;
            end
            apply_tap(row);
            if (row.game) begin
                check_bus_words(1'b1);  // clear screen
            end
            repeat (2 + ($unsigned($random(seed)) % 4)) @(posedge pclk);
            read_host(2'd2, rdata);
            check_data("status", rdata, {30'd0, row.game, 1'b1});
            read_host(2'd0, rdata);
            touch_exp       = '0;
            touch_exp.valid = 1'b1;
            touch_exp.x     = row.x[9:0];
            touch_exp.y     = row.y[9:0];
            check_touch("touch_reg", touch_reg_t'(rdata), touch_exp);
            if (row.lift) begin
                lifts++;
                read_host(2'd1, rdata);
                check_data("count", rdata, 32'(lifts));
            end
        end

        // game state passes each cpu word one cycle later
        for (int i = 0; i <= 6; i++) begin
            rnd = $random(seed);
            @(posedge pclk);
            cpu_wr   <= (i < 6);
            cpu_word <= rnd[16:0];
            @(negedge pclk);
            check_flag("lcd_wr", lcd_wr, i > 0);
            if (i > 0) begin
                check_word("lcd_word", lcd_word, prev_word);
            end
            prev_word = rnd[16:0];
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+sim
verilog/lcd_touch_pkg.sv
verilog/lcd_draw_pkg.sv
verilog/lcd_touch_scanner.sv
verilog/lcd_init.sv
verilog/lcd_core.sv
verilog/lcd_mux.sv
verilog/lcd_ctrl.sv
verilog/lcd_top.sv
sim/tb_lcd_top.sv

// ==== Makefile ====
# verilator flow for the lcd touch front end
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
RTL_TOP   ?= lcd_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
